// File: filelist.f
+incdir+sim
rtl/alpha_pkg.sv
rtl/fetch_wb.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/alpha_core.sv
sim/alpha_core_tb.sv

// File: rtl/alpha_core.sv
`timescale 1ns/1ps

module alpha_core (
  input  logic        clock,
  input  logic        rst_n,
  input  logic [31:0] wb_dat_i,
  input  logic        wb_ack,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic [63:0] wb_adr,
  output logic [4:0]  commit_wr_idx,
  output logic [63:0] commit_wr_data,
  output logic        commit_wr_en,
  output logic [63:0] commit_npc,
  output logic [3:0]  completed_insts,
  output logic [3:0]  error_status
);

  logic        word_valid;
  logic [31:0] word;
  logic [63:0] word_pc;
  logic [4:0]  ra_idx, rb_idx;
  logic [63:0] ra_data, rb_data;

  // Decode to execute
  logic        dec_valid;
  logic [3:0]  alu_op;
  logic [63:0] opa, opb;
  logic [4:0]  dest_idx;
  logic        is_branch, is_cond_branch, branch_on_zero;
  logic [63:0] br_target, npc;
  logic        is_halt, is_illegal;

  logic        ex_valid;
  logic [63:0] result, ex_npc;
  logic [4:0]  dest_idx_q;
  logic        halt_q, illegal_q;

  logic        wr_en;
  logic [4:0]  wr_idx;
  logic [63:0] wr_data;
  logic        retire, stopped;
  logic [63:0] next_pc;

  fetch_wb fetch_wb_inst (
    .clock      (clock),
    .rst_n      (rst_n),
    .wb_dat_i   (wb_dat_i),
    .wb_ack     (wb_ack),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_adr     (wb_adr),
    .retire     (retire),
    .next_pc    (next_pc),
    .stopped    (stopped),
    .word_valid (word_valid),
    .word       (word),
    .word_pc    (word_pc)
  );

  reg_file reg_file_inst (
    .clock   (clock),
    .rst_n   (rst_n),
    .ra_idx  (ra_idx),
    .rb_idx  (rb_idx),
    .ra_data (ra_data),
    .rb_data (rb_data),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_data)
  );

  decode_stage decode_stage_inst (
    .clock          (clock),
    .rst_n          (rst_n),
    .word_valid     (word_valid),
    .word           (word),
    .word_pc        (word_pc),
    .ra_idx         (ra_idx),
    .rb_idx         (rb_idx),
    .ra_data        (ra_data),
    .rb_data        (rb_data),
    .dec_valid      (dec_valid),
    .alu_op         (alu_op),
    .opa            (opa),
    .opb            (opb),
    .dest_idx       (dest_idx),
    .is_branch      (is_branch),
    .is_cond_branch (is_cond_branch),
    .branch_on_zero (branch_on_zero),
    .br_target      (br_target),
    .is_halt        (is_halt),
    .is_illegal     (is_illegal),
    .npc            (npc)
  );

  execute_stage execute_stage_inst (
    .clock          (clock),
    .rst_n          (rst_n),
    .dec_valid      (dec_valid),
    .alu_op         (alu_op),
    .opa            (opa),
    .opb            (opb),
    .dest_idx       (dest_idx),
    .is_branch      (is_branch),
    .is_cond_branch (is_cond_branch),
    .branch_on_zero (branch_on_zero),
    .br_target      (br_target),
    .is_halt        (is_halt),
    .is_illegal     (is_illegal),
    .npc            (npc),
    .ex_valid       (ex_valid),
    .result         (result),
    .dest_idx_q     (dest_idx_q),
    .ex_npc         (ex_npc),
    .halt_q         (halt_q),
    .illegal_q      (illegal_q)
  );

  result_stage result_stage_inst (
    .clock           (clock),
    .rst_n           (rst_n),
    .ex_valid        (ex_valid),
    .result          (result),
    .dest_idx_q      (dest_idx_q),
    .ex_npc          (ex_npc),
    .halt_q          (halt_q),
    .illegal_q       (illegal_q),
    .wr_en           (wr_en),
    .wr_idx          (wr_idx),
    .wr_data         (wr_data),
    .commit_wr_idx   (commit_wr_idx),
    .commit_wr_data  (commit_wr_data),
    .commit_wr_en    (commit_wr_en),
    .commit_npc      (commit_npc),
    .completed_insts (completed_insts),
    .error_status    (error_status),
    .retire          (retire),
    .next_pc         (next_pc),
    .stopped         (stopped)
  );

endmodule

// File: rtl/alpha_pkg.sv
package alpha_pkg;

  localparam int xlen      = 64;
  localparam int inst_w    = 32;
  localparam int reg_idx_w = 5;

  localparam logic [reg_idx_w-1:0] zero_reg = 5'd31;

  // Major opcodes
  localparam logic [5:0] op_pal   = 6'h00;
  localparam logic [5:0] op_lda   = 6'h08;
  localparam logic [5:0] op_ldah  = 6'h09;
  localparam logic [5:0] op_inta  = 6'h10;
  localparam logic [5:0] op_intl  = 6'h11;
  localparam logic [5:0] op_shift = 6'h12;
  localparam logic [5:0] op_br    = 6'h30;
  localparam logic [5:0] op_beq   = 6'h39;
  localparam logic [5:0] op_bne   = 6'h3d;

  localparam logic [6:0] fn_addq   = 7'h20;  // op_inta group
  localparam logic [6:0] fn_subq   = 7'h29;
  localparam logic [6:0] fn_cmpeq  = 7'h2d;
  localparam logic [6:0] fn_cmpult = 7'h1d;
  localparam logic [6:0] fn_and    = 7'h00;  // op_intl group
  localparam logic [6:0] fn_bis    = 7'h20;
  localparam logic [6:0] fn_xor    = 7'h40;
  localparam logic [6:0] fn_sll    = 7'h39;  // op_shift group
  localparam logic [6:0] fn_srl    = 7'h34;

  localparam logic [25:0] pal_halt = 26'h0000000;

  localparam int alu_op_w = 4;

  localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
  localparam logic [alu_op_w-1:0] alu_and    = 4'd2;
  localparam logic [alu_op_w-1:0] alu_or     = 4'd3;
  localparam logic [alu_op_w-1:0] alu_xor    = 4'd4;
  localparam logic [alu_op_w-1:0] alu_sll    = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
  localparam logic [alu_op_w-1:0] alu_cmpeq  = 4'd7;
  localparam logic [alu_op_w-1:0] alu_cmpult = 4'd8;

  localparam logic [3:0] no_error          = 4'h0;
  localparam logic [3:0] halted_on_halt    = 4'h2;
  localparam logic [3:0] halted_on_illegal = 4'h3;

  // One instruction word in its three encodings
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] ra;
      logic [4:0] rb;       // Also the upper literal bits
      logic [2:0] lit_lo;
      logic       is_lit;
      logic [6:0] func;
      logic [4:0] rc;
    } opr;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [15:0] disp;
    } mem;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  ra;
      logic [20:0] disp;
    } br;
  } inst_word_u;

endpackage

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                            clock,
  input  logic                            rst_n,
  input  logic                            word_valid,
  input  logic [alpha_pkg::inst_w-1:0]    word,
  input  logic [alpha_pkg::xlen-1:0]      word_pc,
  output logic [alpha_pkg::reg_idx_w-1:0] ra_idx,
  output logic [alpha_pkg::reg_idx_w-1:0] rb_idx,
  input  logic [alpha_pkg::xlen-1:0]      ra_data,
  input  logic [alpha_pkg::xlen-1:0]      rb_data,
  output logic                            dec_valid,
  output logic [alpha_pkg::alu_op_w-1:0]  alu_op,
  output logic [alpha_pkg::xlen-1:0]      opa,
  output logic [alpha_pkg::xlen-1:0]      opb,
  output logic [alpha_pkg::reg_idx_w-1:0] dest_idx,
  output logic                            is_branch,
  output logic                            is_cond_branch,
  output logic                            branch_on_zero,
  output logic [alpha_pkg::xlen-1:0]      br_target,
  output logic                            is_halt,
  output logic                            is_illegal,
  output logic [alpha_pkg::xlen-1:0]      npc
);

  localparam int xlen = alpha_pkg::xlen;

  alpha_pkg::inst_word_u inst;

  logic [xlen-1:0]                 npc_d, mem_disp, br_disp, lit;
  logic [alpha_pkg::alu_op_w-1:0]  alu_op_d;
  logic [xlen-1:0]                 opa_d, opb_d;
  logic [alpha_pkg::reg_idx_w-1:0] dest_d;
  logic                            branch_d, cond_d, on_zero_d, halt_d, illegal_d;

  assign inst     = word;
  assign ra_idx   = inst.opr.ra;
  assign rb_idx   = inst.opr.rb;
  assign npc_d    = word_pc + 64'd4;
  assign lit      = {{(xlen-8){1'b0}}, inst.opr.rb, inst.opr.lit_lo};
  assign mem_disp = {{(xlen-16){inst.mem.disp[15]}}, inst.mem.disp};
  assign br_disp  = {{(xlen-23){inst.br.disp[20]}}, inst.br.disp, 2'b00};  // Word offset

  always_comb begin
    alu_op_d  = alpha_pkg::alu_add;
    opa_d     = ra_data;
    opb_d     = inst.opr.is_lit ? lit : rb_data;
    dest_d    = inst.opr.rc;
    branch_d  = 1'b0;
    cond_d    = 1'b0;
    on_zero_d = 1'b0;
    halt_d    = 1'b0;
    illegal_d = 1'b0;
    case (inst.opr.opcode)
      alpha_pkg::op_inta:
        case (inst.opr.func)
          alpha_pkg::fn_addq:   alu_op_d = alpha_pkg::alu_add;
          alpha_pkg::fn_subq:   alu_op_d = alpha_pkg::alu_sub;
          alpha_pkg::fn_cmpeq:  alu_op_d = alpha_pkg::alu_cmpeq;
          alpha_pkg::fn_cmpult: alu_op_d = alpha_pkg::alu_cmpult;
          default:              illegal_d = 1'b1;
        endcase
      alpha_pkg::op_intl:
        case (inst.opr.func)
          alpha_pkg::fn_and: alu_op_d = alpha_pkg::alu_and;
          alpha_pkg::fn_bis: alu_op_d = alpha_pkg::alu_or;
          alpha_pkg::fn_xor: alu_op_d = alpha_pkg::alu_xor;
          default:           illegal_d = 1'b1;
        endcase
      alpha_pkg::op_shift:
        case (inst.opr.func)
          alpha_pkg::fn_sll: alu_op_d = alpha_pkg::alu_sll;
          alpha_pkg::fn_srl: alu_op_d = alpha_pkg::alu_srl;
          default:           illegal_d = 1'b1;
        endcase
      alpha_pkg::op_lda, alpha_pkg::op_ldah: begin
        opa_d  = rb_data;
        opb_d  = (inst.mem.opcode == alpha_pkg::op_ldah) ? mem_disp << 16 : mem_disp;
        dest_d = inst.mem.ra;
      end
      alpha_pkg::op_br: begin
        opa_d    = npc_d;  // Return address
        opb_d    = '0;
        dest_d   = inst.br.ra;
        branch_d = 1'b1;
      end
      alpha_pkg::op_beq, alpha_pkg::op_bne: begin
        dest_d    = alpha_pkg::zero_reg;
        branch_d  = 1'b1;
        cond_d    = 1'b1;
        on_zero_d = (inst.br.opcode == alpha_pkg::op_beq);
      end
      alpha_pkg::op_pal: begin
        dest_d    = alpha_pkg::zero_reg;
        halt_d    = ({inst.br.ra, inst.br.disp} == alpha_pkg::pal_halt);
        illegal_d = !halt_d;
      end
      default: begin
        dest_d    = alpha_pkg::zero_reg;
        illegal_d = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n)
      dec_valid <= 1'b0;
    else
      dec_valid <= word_valid;
  end

  always_ff @(posedge clock) begin
    if (word_valid) begin
      alu_op         <= alu_op_d;
      opa            <= opa_d;
      opb            <= opb_d;
      dest_idx       <= dest_d;
      is_branch      <= branch_d;
      is_cond_branch <= cond_d;
      branch_on_zero <= on_zero_d;
      br_target      <= npc_d + br_disp;
      is_halt        <= halt_d;
      is_illegal     <= illegal_d;
      npc            <= npc_d;
    end
  end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                            clock,
  input  logic                            rst_n,
  input  logic                            dec_valid,
  input  logic [alpha_pkg::alu_op_w-1:0]  alu_op,
  input  logic [alpha_pkg::xlen-1:0]      opa,
  input  logic [alpha_pkg::xlen-1:0]      opb,
  input  logic [alpha_pkg::reg_idx_w-1:0] dest_idx,
  input  logic                            is_branch,
  input  logic                            is_cond_branch,
  input  logic                            branch_on_zero,
  input  logic [alpha_pkg::xlen-1:0]      br_target,
  input  logic                            is_halt,
  input  logic                            is_illegal,
  input  logic [alpha_pkg::xlen-1:0]      npc,
  output logic                            ex_valid,
  output logic [alpha_pkg::xlen-1:0]      result,
  output logic [alpha_pkg::reg_idx_w-1:0] dest_idx_q,
  output logic [alpha_pkg::xlen-1:0]      ex_npc,
  output logic                            halt_q,
  output logic                            illegal_q
);

  logic [alpha_pkg::xlen-1:0] alu_out;
  logic                       opa_zero, taken;

  always_comb begin
    case (alu_op)
      alpha_pkg::alu_add:    alu_out = opa + opb;
      alpha_pkg::alu_sub:    alu_out = opa - opb;
      alpha_pkg::alu_and:    alu_out = opa & opb;
      alpha_pkg::alu_or:     alu_out = opa | opb;
      alpha_pkg::alu_xor:    alu_out = opa ^ opb;
      alpha_pkg::alu_sll:    alu_out = opa << opb[5:0];
      alpha_pkg::alu_srl:    alu_out = opa >> opb[5:0];
      alpha_pkg::alu_cmpeq:  alu_out = {63'd0, opa == opb};
      alpha_pkg::alu_cmpult: alu_out = {63'd0, opa < opb};
      default:               alu_out = '0;
    endcase
  end

  // BEQ and BNE test ra, which decode places in opa
  assign opa_zero = (opa == '0);
  assign taken    = is_branch && (!is_cond_branch || (branch_on_zero == opa_zero));

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n)
      ex_valid <= 1'b0;
    else
      ex_valid <= dec_valid;
  end

  always_ff @(posedge clock) begin
    if (dec_valid) begin
      result    <= alu_out;
      ex_npc    <= taken ? br_target : npc;
      halt_q    <= is_halt;
      illegal_q <= is_illegal;
      if (is_cond_branch || is_halt || is_illegal)
        dest_idx_q <= alpha_pkg::zero_reg;  // Nothing to write back
      else
        dest_idx_q <= dest_idx;
    end
  end

endmodule

// File: rtl/fetch_wb.sv
`timescale 1ns/1ps

module fetch_wb (
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic [alpha_pkg::inst_w-1:0] wb_dat_i,
  input  logic                         wb_ack,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic [alpha_pkg::xlen-1:0]   wb_adr,
  input  logic                         retire,
  input  logic [alpha_pkg::xlen-1:0]   next_pc,
  input  logic                         stopped,
  output logic                         word_valid,
  output logic [alpha_pkg::inst_w-1:0] word,
  output logic [alpha_pkg::xlen-1:0]   word_pc
);

  logic                       req_q;     // High in the request state
  logic                       booted_q;
  logic [alpha_pkg::xlen-1:0] pc_q;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      req_q    <= 1'b0;
      booted_q <= 1'b0;
      pc_q     <= '0;
    end else begin
      booted_q <= 1'b1;
      if (retire)
        pc_q <= next_pc;
      // First cycle after reset opens the bus, then one cycle per retire
      if (!req_q)
        req_q <= !booted_q || (retire && !stopped);
      else if (wb_ack)
        req_q <= 1'b0;
    end
  end

  assign wb_cyc = req_q;
  assign wb_stb = req_q;
  assign wb_adr = pc_q;

  assign word_valid = req_q && wb_ack;  // Ack cycle only
  assign word       = wb_dat_i;
  assign word_pc    = pc_q;

  // A stalled request keeps its address until the slave acks
  a_adr_stable: assert property (@(posedge clock) disable iff (!rst_n)
    wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                            clock,
  input  logic                            rst_n,
  input  logic [alpha_pkg::reg_idx_w-1:0] ra_idx,
  input  logic [alpha_pkg::reg_idx_w-1:0] rb_idx,
  output logic [alpha_pkg::xlen-1:0]      ra_data,
  output logic [alpha_pkg::xlen-1:0]      rb_data,
  input  logic                            wr_en,
  input  logic [alpha_pkg::reg_idx_w-1:0] wr_idx,
  input  logic [alpha_pkg::xlen-1:0]      wr_data
);

  logic [alpha_pkg::xlen-1:0] regs [2**alpha_pkg::reg_idx_w];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**alpha_pkg::reg_idx_w; i++)
        regs[i] <= '0;
    end else if (wr_en && wr_idx != alpha_pkg::zero_reg) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // R31 always reads as zero
  assign ra_data = (ra_idx == alpha_pkg::zero_reg) ? '0 : regs[ra_idx];
  assign rb_data = (rb_idx == alpha_pkg::zero_reg) ? '0 : regs[rb_idx];

endmodule

// File: rtl/result_stage.sv
`timescale 1ns/1ps

module result_stage (
  input  logic                            clock,
  input  logic                            rst_n,
  input  logic                            ex_valid,
  input  logic [alpha_pkg::xlen-1:0]      result,
  input  logic [alpha_pkg::reg_idx_w-1:0] dest_idx_q,
  input  logic [alpha_pkg::xlen-1:0]      ex_npc,
  input  logic                            halt_q,
  input  logic                            illegal_q,
  output logic                            wr_en,
  output logic [alpha_pkg::reg_idx_w-1:0] wr_idx,
  output logic [alpha_pkg::xlen-1:0]      wr_data,
  output logic [alpha_pkg::reg_idx_w-1:0] commit_wr_idx,
  output logic [alpha_pkg::xlen-1:0]      commit_wr_data,
  output logic                            commit_wr_en,
  output logic [alpha_pkg::xlen-1:0]      commit_npc,
  output logic [3:0]                      completed_insts,
  output logic [3:0]                      error_status,
  output logic                            retire,
  output logic [alpha_pkg::xlen-1:0]      next_pc,
  output logic                            stopped
);

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      retire       <= 1'b0;
      commit_wr_en <= 1'b0;
      error_status <= alpha_pkg::no_error;
    end else begin
      retire       <= ex_valid;
      commit_wr_en <= ex_valid && dest_idx_q != alpha_pkg::zero_reg;
      // Sticky once set
      if (ex_valid && error_status == alpha_pkg::no_error) begin
        if (halt_q)
          error_status <= alpha_pkg::halted_on_halt;
        else if (illegal_q)
          error_status <= alpha_pkg::halted_on_illegal;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ex_valid) begin
      commit_wr_idx  <= dest_idx_q;
      commit_wr_data <= result;
      commit_npc     <= ex_npc;
    end
  end

  assign wr_en           = commit_wr_en;
  assign wr_idx          = commit_wr_idx;
  assign wr_data         = commit_wr_data;
  assign completed_insts = {3'd0, retire};
  assign next_pc         = commit_npc;
  assign stopped         = (error_status != alpha_pkg::no_error);

  // Halt and illegal retire without a register write
  a_no_commit_on_stop: assert property (@(posedge clock) disable iff (!rst_n)
    ex_valid && (halt_q || illegal_q) |=> !commit_wr_en);

  // Fetch must stay quiet once the core has stopped
  a_no_retire_after_stop: assert property (@(posedge clock) disable iff (!rst_n)
    stopped |=> !retire);

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module alpha_core_tb -o alpha_core_sim

./obj_dir/alpha_core_sim | tee sim.log

if grep -q "All tests passed!" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi

// File: sim/alpha_model.svh
// Architectural model, stepped once per retired instruction
logic [63:0] model_regs [32];
logic [63:0] model_pc;
logic [4:0]  exp_idx;
logic [63:0] exp_data;
logic        exp_en;
logic [63:0] exp_npc;
logic [3:0]  exp_status;
logic        model_done;

function automatic logic [63:0] read_reg(input logic [4:0] idx);
  return (idx == 5'd31) ? 64'd0 : model_regs[idx];
endfunction

task automatic reset_model();
  for (int i = 0; i < 32; i++)
    model_regs[i] = 64'd0;
  model_pc   = 64'd0;
  model_done = 1'b0;
  exp_status = alpha_pkg::no_error;
endtask

task automatic step_model(input logic [31:0] raw);
  alpha_pkg::inst_word_u w;
  logic [63:0] a, b, val, seq, disp, target;
  logic [4:0]  dst;
  logic        bad, halt;
  w      = raw;
  seq    = model_pc + 64'd4;
  a      = read_reg(w.opr.ra);
  b      = w.opr.is_lit ? {56'd0, w.opr.rb, w.opr.lit_lo} : read_reg(w.opr.rb);
  disp   = {{48{w.mem.disp[15]}}, w.mem.disp};
  target = seq + {{41{w.br.disp[20]}}, w.br.disp, 2'b00};
  dst     = w.opr.rc;
  val     = 64'd0;
  bad     = 1'b0;
  halt    = 1'b0;
  exp_npc = seq;
  case (w.opr.opcode)
    alpha_pkg::op_inta, alpha_pkg::op_intl, alpha_pkg::op_shift:
      case ({w.opr.opcode, w.opr.func})
        {alpha_pkg::op_inta, alpha_pkg::fn_addq}:   val = a + b;
        {alpha_pkg::op_inta, alpha_pkg::fn_subq}:   val = a - b;
        {alpha_pkg::op_inta, alpha_pkg::fn_cmpeq}:  val = (a == b) ? 64'd1 : 64'd0;
        {alpha_pkg::op_inta, alpha_pkg::fn_cmpult}: val = (a < b) ? 64'd1 : 64'd0;
        {alpha_pkg::op_intl, alpha_pkg::fn_and}:    val = a & b;
        {alpha_pkg::op_intl, alpha_pkg::fn_bis}:    val = a | b;
        {alpha_pkg::op_intl, alpha_pkg::fn_xor}:    val = a ^ b;
        {alpha_pkg::op_shift, alpha_pkg::fn_sll}:   val = a << b[5:0];
        {alpha_pkg::op_shift, alpha_pkg::fn_srl}:   val = a >> b[5:0];
        default:                                    bad = 1'b1;
      endcase
    alpha_pkg::op_lda: begin
      dst = w.mem.ra;
      val = read_reg(w.mem.rb) + disp;
    end
    alpha_pkg::op_ldah: begin
      dst = w.mem.ra;
      val = read_reg(w.mem.rb) + (disp << 16);
    end
    alpha_pkg::op_br: begin
      dst     = w.br.ra;
      val     = seq;  // Return address
      exp_npc = target;
    end
    alpha_pkg::op_beq, alpha_pkg::op_bne: begin
      dst = 5'd31;
      if ((a == 64'd0) == (w.br.opcode == alpha_pkg::op_beq))
        exp_npc = target;
    end
    alpha_pkg::op_pal: begin
      halt = ({w.br.ra, w.br.disp} == alpha_pkg::pal_halt);
      bad  = !halt;
    end
    default: bad = 1'b1;
  endcase
  if (bad || halt) begin
    dst        = 5'd31;
    model_done = 1'b1;
    exp_status = bad ? alpha_pkg::halted_on_illegal : alpha_pkg::halted_on_halt;
  end
  exp_idx  = dst;
  exp_en   = (dst != 5'd31);
  exp_data = val;
  if (exp_en)
    model_regs[dst] = val;
  model_pc = exp_npc;
endtask

// File: sim/alpha_core_tb.sv
`timescale 1ns/1ps

module alpha_core_tb;

  localparam int num_programs    = 9;  // Last one ends on an illegal opcode
  localparam int prog_len        = 32;
  localparam int watchdog_cycles = num_programs * prog_len * 12 + 2000;

  // Operate instructions as {opcode, func}
  localparam logic [12:0] opr_table [9] = '{
    {alpha_pkg::op_inta, alpha_pkg::fn_addq}, {alpha_pkg::op_inta, alpha_pkg::fn_subq},
    {alpha_pkg::op_inta, alpha_pkg::fn_cmpeq}, {alpha_pkg::op_inta, alpha_pkg::fn_cmpult},
    {alpha_pkg::op_intl, alpha_pkg::fn_and}, {alpha_pkg::op_intl, alpha_pkg::fn_bis},
    {alpha_pkg::op_intl, alpha_pkg::fn_xor}, {alpha_pkg::op_shift, alpha_pkg::fn_sll},
    {alpha_pkg::op_shift, alpha_pkg::fn_srl}
  };
  localparam logic [5:0] br_ops [3] = '{alpha_pkg::op_br, alpha_pkg::op_beq, alpha_pkg::op_bne};

  logic        clock;
  logic        rst_n = 1'b0;
  logic [31:0] wb_dat_i = 32'd0;
  logic        wb_ack = 1'b0;
  logic        wb_cyc, wb_stb;
  logic [63:0] wb_adr;
  logic [4:0]  commit_wr_idx;
  logic [63:0] commit_wr_data, commit_npc;
  logic        commit_wr_en;
  logic [3:0]  completed_insts, error_status;

  integer      seed = 53927;
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;
  logic [31:0] prog_mem [256];
  int          ack_wait = -1;  // -1 while no request is open
  logic [63:0] held_adr;

  `include "alpha_model.svh"

  alpha_core alpha_core_inst (
    .clock           (clock),
    .rst_n           (rst_n),
    .wb_dat_i        (wb_dat_i),
    .wb_ack          (wb_ack),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_adr          (wb_adr),
    .commit_wr_idx   (commit_wr_idx),
    .commit_wr_data  (commit_wr_data),
    .commit_wr_en    (commit_wr_en),
    .commit_npc      (commit_npc),
    .completed_insts (completed_insts),
    .error_status    (error_status)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  // Wishbone slave with a random 0 to 3 cycle wait before each ack
  always @(negedge clock) begin
    logic [31:0] r;
    if (wb_ack) begin
      wb_ack   = 1'b0;
      ack_wait = -1;
    end else if (wb_cyc || wb_stb) begin
      check_value("wb_cyc", 64'(wb_cyc), 64'd1);  // A read holds both high
      check_value("wb_stb", 64'(wb_stb), 64'd1);
      if (ack_wait < 0) begin
        r        = $random(seed);
        ack_wait = int'(r[1:0]);
        held_adr = wb_adr;
        check_value("wb_adr", wb_adr, model_pc);
      end else begin
        check_value("wb_adr (stall)", wb_adr, held_adr);
      end
      if (ack_wait == 0) begin
        wb_dat_i = prog_mem[wb_adr[9:2]];
        wb_ack   = 1'b1;
      end else
        ack_wait--;
    end
  end

  task automatic make_program(input bit end_illegal);
    alpha_pkg::inst_word_u w;
    logic [31:0] r;
    int          room;
    for (int i = 0; i < prog_len - 1; i++) begin
      r = $random(seed);
      w = $random(seed);  // Registers, literal and displacement start random
      case (int'(r[7:0]) % 7)
        4, 5: w.mem.opcode = r[16] ? alpha_pkg::op_ldah : alpha_pkg::op_lda;
        6: begin
          room = prog_len - 2 - i;  // Forward only, never past the last word
          if (room > 3)
            room = 3;
          w.br.opcode = br_ops[int'(r[17:16]) % 3];
          w.br.disp   = 21'(int'(r[23:16]) % (room + 1));
        end
        default: {w.opr.opcode, w.opr.func} = opr_table[int'(r[15:8]) % 9];
      endcase
      prog_mem[i] = w;
    end
    r = $random(seed);
    w = {alpha_pkg::op_pal, alpha_pkg::pal_halt};
    if (end_illegal) begin
      w = $random(seed);
      w.opr.opcode = 6'd1 + 6'(r[1:0]);  // Opcodes 1 to 4 are unused
    end
    prog_mem[prog_len - 1] = w;
  endtask

  task automatic run_program(input int num, input bit end_illegal);
    int start_errors;
    int retired;
    start_errors = errors;
    retired      = 0;
    reset_model();
    rst_n = 1'b0;
    repeat (16) @(negedge clock);
    check_value("wb_cyc", 64'(wb_cyc), 64'd0);
    check_value("wb_stb", 64'(wb_stb), 64'd0);
    check_value("commit_wr_en", 64'(commit_wr_en), 64'd0);
    check_value("completed_insts", 64'(completed_insts), 64'd0);
    check_value("error_status", 64'(error_status), 64'(alpha_pkg::no_error));
    rst_n = 1'b1;
    while (!model_done) begin
      @(negedge clock);
      if (completed_insts == 4'd1) begin
        step_model(prog_mem[model_pc[9:2]]);
        retired++;
        check_value("commit_wr_en", 64'(commit_wr_en), 64'(exp_en));
        if (exp_en) begin
          check_value("commit_wr_idx", 64'(commit_wr_idx), 64'(exp_idx));
          check_value("commit_wr_data", commit_wr_data, exp_data);
        end
        check_value("commit_npc", commit_npc, exp_npc);
        check_value("error_status", 64'(error_status), 64'(exp_status));
      end else begin
        check_value("completed_insts", 64'(completed_insts), 64'd0);
        check_value("commit_wr_en", 64'(commit_wr_en), 64'd0);
      end
    end
    repeat (50) begin
      @(negedge clock);
      check_value("wb_cyc (stopped)", 64'(wb_cyc), 64'd0);
      check_value("wb_stb (stopped)", 64'(wb_stb), 64'd0);
    end
    check_value("error_status", 64'(error_status), 64'(end_illegal ?
                alpha_pkg::halted_on_illegal : alpha_pkg::halted_on_halt));
    if (errors == start_errors)
      passed++;
    else
      failed++;
    $display("Program %0d (%s end): %0d retired, %0d errors", num,
             end_illegal ? "illegal" : "halt", retired, errors - start_errors);
  endtask

  initial begin
    for (int p = 0; p < num_programs; p++) begin
      make_program(p == num_programs - 1);
      run_program(p, p == num_programs - 1);
    end
    $display("Programs passed: %0d, failed: %0d, mismatches: %0d", passed, failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("Timeout: the core did not finish all programs within %0d cycles",
             watchdog_cycles);
    $display("Test failures found");
    $finish;
  end

endmodule
